//--- source/fifo_cfg_pkg.sv
package fifo_cfg_pkg;

  // Default word width in bits.
  localparam int DEF_DATA_WIDTH = 8;

  // Number of entries. Must be a power of two.
  localparam int DEF_FIFO_DEPTH = 16;

  // Almost-full is raised at this level or above.
  localparam int DEF_AFULL = 14;

  // Almost-empty is raised at this level or below.
  localparam int DEF_AEMPTY = 2;

endpackage

//--- source/fifo_gray_pkg.sv
package fifo_gray_pkg;

  // Pointers are passed in a 32-bit word, only the low width bits count.
  function automatic logic [31:0] width_mask(input int width);
    logic [31:0] mask;
    if (width >= 32) begin
      mask = '1;
    end else begin
      mask = (32'd1 << width) - 32'd1;
    end
    return mask;
  endfunction

  function automatic logic [31:0] bin_to_gray(input logic [31:0] bin, input int width);
    logic [31:0] b;
    b = bin & width_mask(width);
    return b ^ (b >> 1);
  endfunction

  function automatic logic [31:0] gray_to_bin(input logic [31:0] gray, input int width);
    logic [31:0] g;
    logic [31:0] bin;
    g = gray & width_mask(width);
    bin = '0;
    for (int i = 0; i < 32; i++) begin
      bin[i] = ^(g >> i); // XOR of this bit and all above.
    end
    return bin;
  endfunction

endpackage

//--- source/dualport_ram.sv
`timescale 1ns/1ps

module dualport_ram #(
  parameter int DATA_WIDTH = 8,
  parameter int ADDR_WIDTH = 4
) (
  input  logic                  wr_clk,
  input  logic                  ram_we,
  input  logic [ADDR_WIDTH-1:0] ram_waddr,
  input  logic [DATA_WIDTH-1:0] wr_data,
  input  logic                  rd_clk,
  input  logic                  ram_re,
  input  logic [ADDR_WIDTH-1:0] ram_raddr,
  output logic [DATA_WIDTH-1:0] rd_data
);

  localparam int DEPTH = 1 << ADDR_WIDTH;

  logic [DATA_WIDTH-1:0] mem [DEPTH];

  // Write port.
  always_ff @(posedge wr_clk) begin
    if (ram_we) begin
      mem[ram_waddr] <= wr_data;
    end
  end

  // Read register holds its word until the next accepted read.
  always_ff @(posedge rd_clk) begin
    if (ram_re) begin
      rd_data <= mem[ram_raddr];
    end
  end

endmodule

//--- source/gray_sync.sv
`timescale 1ns/1ps

module gray_sync #(
  parameter int WIDTH = 5
) (
  input  logic             clk,
  input  logic             rst_n,
  input  logic [WIDTH-1:0] gray_in,
  output logic [WIDTH-1:0] gray_out
);

  logic [WIDTH-1:0] gray_meta; // First stage, may go metastable.

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      gray_meta <= '0;
      gray_out  <= '0;
    end else begin
      gray_meta <= gray_in;
      gray_out  <= gray_meta;
    end
  end

endmodule

//--- source/fifo_wr_ctrl.sv
`timescale 1ns/1ps

module fifo_wr_ctrl import fifo_gray_pkg::*; #(
  parameter int ADDR_WIDTH = 4,
  parameter int AFULL      = 14
) (
  input  logic                  wr_clk,
  input  logic                  wr_rst_n,
  input  logic                  wr_en,
  input  logic [ADDR_WIDTH:0]   rd_ptr_gray_sync,
  output logic                  ram_we,
  output logic [ADDR_WIDTH-1:0] ram_waddr,
  output logic [ADDR_WIDTH:0]   wr_ptr_gray,
  output logic                  full,
  output logic                  afull
);

  localparam int PTR_W = ADDR_WIDTH + 1;

  // Full when the pointers differ only in the two top Gray bits.
  localparam logic [ADDR_WIDTH:0] FULL_MASK = {2'b11, {(ADDR_WIDTH-1){1'b0}}};

  logic [ADDR_WIDTH:0] wr_ptr;
  logic [ADDR_WIDTH:0] wr_ptr_nxt;
  logic [ADDR_WIDTH:0] wr_gray_nxt;
  logic [ADDR_WIDTH:0] rd_ptr_bin;
  logic [ADDR_WIDTH:0] level_nxt;

  assign ram_we    = wr_en & ~full; // Writes while full are dropped.
  assign ram_waddr = wr_ptr[ADDR_WIDTH-1:0];

  assign wr_ptr_nxt  = ram_we ? wr_ptr + 1'b1 : wr_ptr;
  assign wr_gray_nxt = PTR_W'(bin_to_gray(32'(wr_ptr_nxt), PTR_W));
  assign rd_ptr_bin  = PTR_W'(gray_to_bin(32'(rd_ptr_gray_sync), PTR_W));

  // Level seen from this side, stale by the sync delay.
  assign level_nxt = wr_ptr_nxt - rd_ptr_bin;

  always_ff @(posedge wr_clk or negedge wr_rst_n) begin
    if (!wr_rst_n) begin
      wr_ptr      <= '0;
      wr_ptr_gray <= '0;
      full        <= 1'b0;
      afull       <= 1'b0;
    end else begin
      wr_ptr      <= wr_ptr_nxt;
      wr_ptr_gray <= wr_gray_nxt;
      full        <= (wr_gray_nxt == (rd_ptr_gray_sync ^ FULL_MASK));
      afull       <= (level_nxt >= PTR_W'(AFULL));
    end
  end

  // Never more than a full FIFO ahead of the read side.
  a_no_overrun: assert property (
    @(posedge wr_clk) disable iff (!wr_rst_n)
    (wr_ptr - rd_ptr_bin) <= PTR_W'(1 << ADDR_WIDTH)
  );

  // The read side samples this pointer, so it must step one bit at a time.
  a_gray_step: assert property (
    @(posedge wr_clk) disable iff (!wr_rst_n)
    $countones(wr_ptr_gray ^ $past(wr_ptr_gray)) <= 1
  );

endmodule

//--- source/fifo_rd_ctrl.sv
`timescale 1ns/1ps

module fifo_rd_ctrl import fifo_gray_pkg::*; #(
  parameter int ADDR_WIDTH = 4,
  parameter int AEMPTY     = 2
) (
  input  logic                  rd_clk,
  input  logic                  rd_rst_n,
  input  logic                  rd_en,
  input  logic [ADDR_WIDTH:0]   wr_ptr_gray_sync,
  output logic                  ram_re,
  output logic [ADDR_WIDTH-1:0] ram_raddr,
  output logic [ADDR_WIDTH:0]   rd_ptr_gray,
  output logic                  rd_valid,
  output logic                  empty,
  output logic                  aempty
);

  localparam int PTR_W = ADDR_WIDTH + 1;

  logic [ADDR_WIDTH:0] rd_ptr;
  logic [ADDR_WIDTH:0] rd_ptr_nxt;
  logic [ADDR_WIDTH:0] rd_gray_nxt;
  logic [ADDR_WIDTH:0] wr_ptr_bin;
  logic [ADDR_WIDTH:0] level_nxt;

  assign ram_re    = rd_en & ~empty; // Reads while empty are ignored.
  assign ram_raddr = rd_ptr[ADDR_WIDTH-1:0];

  assign rd_ptr_nxt  = ram_re ? rd_ptr + 1'b1 : rd_ptr;
  assign rd_gray_nxt = PTR_W'(bin_to_gray(32'(rd_ptr_nxt), PTR_W));
  assign wr_ptr_bin  = PTR_W'(gray_to_bin(32'(wr_ptr_gray_sync), PTR_W));

  assign level_nxt = wr_ptr_bin - rd_ptr_nxt;

  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      rd_ptr      <= '0;
      rd_ptr_gray <= '0;
      rd_valid    <= 1'b0;
      empty       <= 1'b1;
      aempty      <= 1'b1;
    end else begin
      rd_ptr      <= rd_ptr_nxt;
      rd_ptr_gray <= rd_gray_nxt;
      rd_valid    <= ram_re; // RAM output is ready one cycle later.
      empty       <= (rd_gray_nxt == wr_ptr_gray_sync);
      aempty      <= (level_nxt <= PTR_W'(AEMPTY));
    end
  end

  // Reads never run past the write pointer seen here.
  a_no_underrun: assert property (
    @(posedge rd_clk) disable iff (!rd_rst_n)
    (wr_ptr_bin - rd_ptr) <= PTR_W'(1 << ADDR_WIDTH)
  );

  a_gray_step: assert property (
    @(posedge rd_clk) disable iff (!rd_rst_n)
    $countones(rd_ptr_gray ^ $past(rd_ptr_gray)) <= 1
  );

endmodule

//--- source/async_fifo.sv
`timescale 1ns/1ps

module async_fifo import fifo_cfg_pkg::*; #(
  parameter int DATA_WIDTH = DEF_DATA_WIDTH,
  parameter int FIFO_DEPTH = DEF_FIFO_DEPTH,
  parameter int AFULL      = DEF_AFULL,
  parameter int AEMPTY     = DEF_AEMPTY
) (
  input  logic                  wr_clk,
  input  logic                  wr_rst_n,
  input  logic                  wr_en,
  input  logic [DATA_WIDTH-1:0] wr_data,
  input  logic                  rd_clk,
  input  logic                  rd_rst_n,
  input  logic                  rd_en,
  output logic [DATA_WIDTH-1:0] rd_data,
  output logic                  rd_valid,
  output logic                  full,
  output logic                  afull,
  output logic                  empty,
  output logic                  aempty
);

  localparam int ADDR_WIDTH = $clog2(FIFO_DEPTH);

  logic                  ram_we;
  logic [ADDR_WIDTH-1:0] ram_waddr;
  logic                  ram_re;
  logic [ADDR_WIDTH-1:0] ram_raddr;

  logic [ADDR_WIDTH:0] wr_ptr_gray;
  logic [ADDR_WIDTH:0] wr_ptr_gray_sync; // In rd_clk domain.
  logic [ADDR_WIDTH:0] rd_ptr_gray;
  logic [ADDR_WIDTH:0] rd_ptr_gray_sync; // In wr_clk domain.

  fifo_wr_ctrl #(
    .ADDR_WIDTH (ADDR_WIDTH),
    .AFULL      (AFULL)
  ) wr_ctrl (
    .wr_clk           (wr_clk),
    .wr_rst_n         (wr_rst_n),
    .wr_en            (wr_en),
    .rd_ptr_gray_sync (rd_ptr_gray_sync),
    .ram_we           (ram_we),
    .ram_waddr        (ram_waddr),
    .wr_ptr_gray      (wr_ptr_gray),
    .full             (full),
    .afull            (afull)
  );

  fifo_rd_ctrl #(
    .ADDR_WIDTH (ADDR_WIDTH),
    .AEMPTY     (AEMPTY)
  ) rd_ctrl (
    .rd_clk           (rd_clk),
    .rd_rst_n         (rd_rst_n),
    .rd_en            (rd_en),
    .wr_ptr_gray_sync (wr_ptr_gray_sync),
    .ram_re           (ram_re),
    .ram_raddr        (ram_raddr),
    .rd_ptr_gray      (rd_ptr_gray),
    .rd_valid         (rd_valid),
    .empty            (empty),
    .aempty           (aempty)
  );

  gray_sync #(.WIDTH(ADDR_WIDTH + 1)) sync_w2r (
    .clk      (rd_clk),
    .rst_n    (rd_rst_n),
    .gray_in  (wr_ptr_gray),
    .gray_out (wr_ptr_gray_sync)
  );

  gray_sync #(.WIDTH(ADDR_WIDTH + 1)) sync_r2w (
    .clk      (wr_clk),
    .rst_n    (wr_rst_n),
    .gray_in  (rd_ptr_gray),
    .gray_out (rd_ptr_gray_sync)
  );

  dualport_ram #(
    .DATA_WIDTH (DATA_WIDTH),
    .ADDR_WIDTH (ADDR_WIDTH)
  ) ram (
    .wr_clk    (wr_clk),
    .ram_we    (ram_we),
    .ram_waddr (ram_waddr),
    .wr_data   (wr_data),
    .rd_clk    (rd_clk),
    .ram_re    (ram_re),
    .ram_raddr (ram_raddr),
    .rd_data   (rd_data)
  );

endmodule

//--- bench/async_fifo_tb.sv
`timescale 1ns/1ps

module async_fifo_tb import fifo_cfg_pkg::*; ();

  localparam int WR_PERIOD = 100;
  localparam int RD_PERIOD = 130;
  localparam int DRIVE_DLY = 10;
  localparam int WD_MARGIN = 20000;
  localparam logic [31:0] SEED = 32'h328a_4f5d;
  localparam int NUM_ROWS  = 9;

  // Test table: name, write cycles, read cycles, concurrent, level after (-1 if random).
  string row_name  [NUM_ROWS] = '{"fill", "drain", "partial", "to_afull", "burst_mix",
                                  "drain_rest", "low_level", "stream", "final_drain"};
  int    row_wr    [NUM_ROWS] = '{20,  0, 13,  2,  60,  0,  2, 200,  0};
  int    row_rd    [NUM_ROWS] = '{ 0, 20,  0,  0,  60, 40,  0, 220, 30};
  bit    row_conc  [NUM_ROWS] = '{ 0,  0,  0,  0,   1,  0,  0,   1,  0};
  int    row_level [NUM_ROWS] = '{16,  0, 13, 15,  -1,  0,  2,  -1,  0};

  logic                      wr_clk;
  logic                      wr_rst_n;
  logic                      wr_en;
  logic [DEF_DATA_WIDTH-1:0] wr_data;
  logic                      rd_clk;
  logic                      rd_rst_n;
  logic                      rd_en;
  logic [DEF_DATA_WIDTH-1:0] rd_data;
  logic                      rd_valid;
  logic                      full;
  logic                      afull;
  logic                      empty;
  logic                      aempty;

  logic [DEF_DATA_WIDTH-1:0] ref_q [$]; // Words accepted but not yet read.
  int errors     = 0;
  int checks     = 0;
  int words_read = 0;

  async_fifo dut0 (
    .wr_clk   (wr_clk),
    .wr_rst_n (wr_rst_n),
    .wr_en    (wr_en),
    .wr_data  (wr_data),
    .rd_clk   (rd_clk),
    .rd_rst_n (rd_rst_n),
    .rd_en    (rd_en),
    .rd_data  (rd_data),
    .rd_valid (rd_valid),
    .full     (full),
    .afull    (afull),
    .empty    (empty),
    .aempty   (aempty)
  );

  initial begin
    wr_clk = 1'b0;
    forever #(WR_PERIOD / 2) wr_clk = ~wr_clk;
  end

  // Small start offset keeps the two clocks' edges apart.
  initial begin
    rd_clk = 1'b0;
    #7;
    forever #(RD_PERIOD / 2) rd_clk = ~rd_clk;
  end

  task automatic check_val(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
    checks++;
    if (actual !== expected) begin
      $display("CHECK FAILED at %0t: %s expected %0h, got %0h", $time, name, expected, actual);
      errors++;
    end
  endtask

  // Accept is judged mid-cycle, where wr_en and full are both stable.
  task automatic write_words(input int count, input bit random_rate, input bit track_full);
    for (int i = 0; i < count; i++) begin
      @(posedge wr_clk);
      #DRIVE_DLY;
      wr_data = DEF_DATA_WIDTH'($urandom);
      wr_en   = random_rate ? 1'($urandom_range(0, 1)) : 1'b1;
      @(negedge wr_clk);
      if (track_full) check_val("full", 32'(ref_q.size() == DEF_FIFO_DEPTH), 32'(full));
      if (wr_en && !full) ref_q.push_back(wr_data);
    end
    @(posedge wr_clk);
    #DRIVE_DLY;
    wr_en = 1'b0;
    @(negedge wr_clk);
    if (track_full) check_val("full", 32'(ref_q.size() == DEF_FIFO_DEPTH), 32'(full));
  endtask

  task automatic read_words(input int count, input bit random_rate);
    for (int i = 0; i < count; i++) begin
      @(posedge rd_clk);
      #DRIVE_DLY;
      rd_en = random_rate ? 1'($urandom_range(0, 1)) : 1'b1;
    end
    @(posedge rd_clk);
    #DRIVE_DLY;
    rd_en = 1'b0;
  endtask

  task automatic settle();
    repeat (6) @(posedge wr_clk);
    repeat (6) @(posedge rd_clk);
    @(negedge rd_clk);
  endtask

  task automatic check_flags();
    int level;
    level = ref_q.size();
    check_val("afull", 32'(level >= DEF_AFULL), 32'(afull));
    check_val("aempty", 32'(level <= DEF_AEMPTY), 32'(aempty));
    check_val("full", 32'(level == DEF_FIFO_DEPTH), 32'(full));
    check_val("empty", 32'(level == 0), 32'(empty));
  endtask

  // Every valid word must match the oldest accepted write.
  always @(negedge rd_clk) begin
    if (rd_rst_n && rd_valid) begin
      if (ref_q.size() == 0) begin
        $display("Error at %0t: rd_valid was high with no word left to read", $time);
        errors++;
      end else begin
        check_val("rd_data", 32'(ref_q.pop_front()), 32'(rd_data));
        words_read++;
      end
    end
  end

  initial begin
    int total;
    total = 0;
    for (int r = 0; r < NUM_ROWS; r++) total += row_wr[r] + row_rd[r];
    #(total * 4 * RD_PERIOD + WD_MARGIN);
    $display("Watchdog expired: the tests did not finish in the allowed time");
    $display("Regression failed");
    $finish;
  end

  initial begin
    int errs_before;
    wr_rst_n = 1'b0;
    rd_rst_n = 1'b0;
    wr_en    = 1'b0;
    wr_data  = '0;
    rd_en    = 1'b0;
    void'($urandom(SEED));

    fork
      begin
        repeat (5) @(posedge wr_clk);
        #DRIVE_DLY;
        wr_rst_n = 1'b1;
      end
      begin
        repeat (5) @(posedge rd_clk);
        #DRIVE_DLY;
        rd_rst_n = 1'b1;
      end
    join
    @(negedge rd_clk);
    check_val("empty", 32'd1, 32'(empty));
    check_val("aempty", 32'd1, 32'(aempty));
    check_val("full", 32'd0, 32'(full));
    check_val("afull", 32'd0, 32'(afull));
    check_val("rd_valid", 32'd0, 32'(rd_valid));
    $display("Test %s %s", "reset", (errors == 0) ? "ok" : "FAIL");

    for (int r = 0; r < NUM_ROWS; r++) begin
      errs_before = errors;
      words_read  = 0;
      if (row_conc[r]) begin
        fork
          write_words(row_wr[r], 1'b1, 1'b0);
          read_words(row_rd[r], 1'b1);
        join
      end else begin
        if (row_wr[r] > 0) begin
          write_words(row_wr[r], 1'b0, 1'b1);
          settle(); // Pointer must cross before reads start.
        end
        if (row_rd[r] > 0) read_words(row_rd[r], 1'b0);
      end
      settle();
      check_flags();
      if (row_level[r] >= 0) check_val("level", 32'(row_level[r]), 32'(ref_q.size()));
      $display("Test %s %s  words read %0d, level %0d", row_name[r],
               (errors == errs_before) ? "ok" : "FAIL", words_read, ref_q.size());
    end

    $display("Summary: %0d tests, %0d checks, %0d errors", NUM_ROWS + 1, checks, errors);
    if (errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

//--- sim.f
source/fifo_cfg_pkg.sv
source/fifo_gray_pkg.sv
source/dualport_ram.sv
source/gray_sync.sv
source/fifo_wr_ctrl.sv
source/fifo_rd_ctrl.sv
source/async_fifo.sv
bench/async_fifo_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the async FIFO testbench with Verilator, result goes to sim.log.
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module async_fifo_tb -f sim.f -o async_fifo_sim > sim.log 2>&1 &&
  ./obj_dir/async_fifo_sim >> sim.log 2>&1 ||
  { echo "Build or simulation exited with an error" >> sim.log;
    echo "Regression failed" >> sim.log; }

if grep -q "Regression failed" sim.log; then
  echo "FAIL, see sim.log"
  exit 1
fi
echo "PASS, see sim.log"
exit 0
